/* hdl/rasterTypes.sv */
package rasterTypes;

	// one 16-bit framebuffer pixel, rgb565 packing
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} pixelRgb565;

	// screen coordinate, enough for 640x480
	typedef logic [9:0] screenCoord;

	// upper-left pixel of a tile
	typedef struct packed {
		screenCoord x;
		screenCoord y;
	} tileOrigin;

	// linear framebuffer address width
	parameter int fbAddrWidth = 20;

	// one framebuffer pixel write
	// addr is y * screenWidth + x
	typedef struct packed {
		logic valid;
		logic [fbAddrWidth-1:0] addr;
		pixelRgb565 pixel;
	} fbWrite;

endpackage

/* hdl/configTypes.sv */
package configTypes;

	// register select, one bit
	typedef logic cfgAddr;

	localparam cfgAddr addrFillColor = 1'b0;
	localparam cfgAddr addrMode = 1'b1;

	// value 3 falls back to solid
	typedef enum logic [1:0] {
		shadeSolid = 2'd0,
		shadeChecker = 2'd1,
		shadeGradient = 2'd2
	} shadeMode;

	// checkerLog picks square side 1, 2, 4 or 8 pixels
	typedef struct packed {
		logic [11:0] reserved;
		logic [1:0] checkerLog;
		shadeMode mode;
	} modeWord;

	// same write word, read as color or as mode by address
	typedef union packed {
		rasterTypes::pixelRgb565 color;
		modeWord mode;
	} cfgWord;

	typedef struct packed {
		logic strobe;
		cfgAddr addr;
		cfgWord data;
	} cfgWrite;

	typedef struct packed {
		rasterTypes::pixelRgb565 fillColor;
		modeWord shading;
	} renderSettings;

endpackage

/* hdl/renderConfig.sv */
`timescale 1ns/1ps

module renderConfig (
	input logic BOARD_CLK,
	input logic reset,
	input configTypes::cfgWrite cfgIn,
	input logic frameStart,
	output configTypes::renderSettings settings
);

	// written by the host at any time
	configTypes::renderSettings pending;

	// pending side, decoded by address
	always_ff @(posedge BOARD_CLK) begin
		if (reset) begin
			// fill black, solid, checkerLog 0
			pending <= '0;
		end else if (cfgIn.strobe) begin
			case (cfgIn.addr)
				configTypes::addrFillColor: begin
					pending.fillColor <= cfgIn.data.color;
				end
				configTypes::addrMode: begin
					pending.shading <= cfgIn.data.mode;
				end
				default: begin
					pending <= pending;
				end
			endcase
		end
	end

	// active side
	// only moves at frame start so a whole frame
	// renders with one set of values
	always_ff @(posedge BOARD_CLK) begin
		if (reset) begin
			settings <= '0;
		end else if (frameStart) begin
			settings <= pending;
		end
	end

endmodule

/* hdl/tileScheduler.sv */
`timescale 1ns/1ps

module tileScheduler #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480,
	parameter int tileDim = 8
) (
	input logic BOARD_CLK,
	input logic reset,
	input logic startFrame,
	output logic frameStart,
	output logic busy,
	output logic frameDone,
	output logic shadeStart,
	output rasterTypes::tileOrigin shadeOrigin,
	output logic shadeBuf,
	input logic shadeDone,
	output logic streamStart,
	output rasterTypes::tileOrigin streamOrigin,
	output logic streamBuf,
	input logic streamDone
);

	typedef enum logic [1:0] {
		idle,
		shade,
		overlap,
		drain
	} schedState;

	schedState state;

	// done events already seen in this overlap step
	logic shadeSeen;
	logic streamSeen;
	logic shadeOk;
	logic streamOk;
	logic handoff;
	logic rowEnd;
	logic lastTile;
	rasterTypes::tileOrigin nextOrigin;

	// done events may land in either order
	assign shadeOk = shadeSeen | shadeDone;
	assign streamOk = streamSeen | streamDone;

	// tile just shaded can go to the streamer
	assign handoff = (state == shade && shadeDone) ||
		(state == overlap && shadeOk && streamOk);

	assign rowEnd = (int'(shadeOrigin.x) + tileDim) == screenWidth;
	// bottom-right tile ends the frame
	assign lastTile = rowEnd && ((int'(shadeOrigin.y) + tileDim) == screenHeight);

	// raster order, left to right then down
	always_comb begin
		nextOrigin = shadeOrigin;
		if (rowEnd) begin
			nextOrigin.x = '0;
			nextOrigin.y = shadeOrigin.y + rasterTypes::screenCoord'(tileDim);
		end else begin
			nextOrigin.x = shadeOrigin.x + rasterTypes::screenCoord'(tileDim);
		end
	end

	always_ff @(posedge BOARD_CLK) begin
		if (reset) begin
			state <= idle;
			busy <= 1'b0;
			frameStart <= 1'b0;
			frameDone <= 1'b0;
			shadeStart <= 1'b0;
			streamStart <= 1'b0;
			shadeSeen <= 1'b0;
			streamSeen <= 1'b0;
			shadeOrigin <= '0;
			shadeBuf <= 1'b0;
			streamOrigin <= '0;
			streamBuf <= 1'b0;
		end else begin
			// strobes default low
			frameStart <= 1'b0;
			frameDone <= 1'b0;
			shadeStart <= 1'b0;
			streamStart <= 1'b0;
			// busy falls the cycle after frameDone
			if (frameDone) begin
				busy <= 1'b0;
			end
			case (state)
				idle: begin
					// starts while busy are dropped
					if (startFrame && !busy) begin
						busy <= 1'b1;
						frameStart <= 1'b1;
						shadeStart <= 1'b1;
						shadeOrigin <= '0;
						state <= shade;
					end
				end
				overlap: begin
					if (!handoff) begin
						shadeSeen <= shadeOk;
						streamSeen <= streamOk;
					end
				end
				drain: begin
					if (streamDone) begin
						frameDone <= 1'b1;
						state <= idle;
					end
				end
				default: begin
					// shade, first tile only, waits in handoff below
					state <= state;
				end
			endcase
			if (handoff) begin
				// streamer takes the finished half, shader flips
				streamStart <= 1'b1;
				streamOrigin <= shadeOrigin;
				streamBuf <= shadeBuf;
				shadeBuf <= ~shadeBuf;
				shadeSeen <= 1'b0;
				streamSeen <= 1'b0;
				if (lastTile) begin
					state <= drain;
				end else begin
					shadeOrigin <= nextOrigin;
					shadeStart <= 1'b1;
					state <= overlap;
				end
			end
		end
	end

endmodule

/* hdl/tileShader.sv */
`timescale 1ns/1ps

module tileShader #(
	parameter int tileDim = 8
) (
	input logic BOARD_CLK,
	input logic reset,
	input logic shadeStart,
	input rasterTypes::tileOrigin shadeOrigin,
	input logic shadeBuf,
	input configTypes::renderSettings settings,
	output logic shadeDone,
	output logic wrEn,
	output logic wrBuf,
	output logic [$clog2(tileDim*tileDim)-1:0] wrIndex,
	output rasterTypes::pixelRgb565 wrPixel
);

	localparam int coordWidth = $clog2(tileDim);
	localparam int idxWidth = $clog2(tileDim*tileDim);

	logic active;
	logic [coordWidth-1:0] col;
	logic [coordWidth-1:0] row;
	logic lastPixel;
	rasterTypes::tileOrigin origin;
	logic curBuf;
	rasterTypes::screenCoord x;
	rasterTypes::screenCoord y;
	rasterTypes::screenCoord checkerBits;
	rasterTypes::pixelRgb565 fill;

	assign lastPixel = (col == coordWidth'(tileDim - 1)) && (row == coordWidth'(tileDim - 1));

	// one pixel per cycle, row-major
	always_ff @(posedge BOARD_CLK) begin
		if (reset) begin
			active <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (shadeStart) begin
			active <= 1'b1;
			col <= '0;
			row <= '0;
		end else if (active) begin
			if (col == coordWidth'(tileDim - 1)) begin
				col <= '0;
				row <= row + 1'b1;
				if (lastPixel) begin
					active <= 1'b0;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// tile position and target half, held for the whole tile
	always_ff @(posedge BOARD_CLK) begin
		if (shadeStart) begin
			origin <= shadeOrigin;
			curBuf <= shadeBuf;
		end
	end

	// screen position of the current pixel
	assign x = origin.x + rasterTypes::screenCoord'(col);
	assign y = origin.y + rasterTypes::screenCoord'(row);
	assign checkerBits = x ^ y;
	assign fill = settings.fillColor;

	always_comb begin
		case (settings.shading.mode)
			configTypes::shadeChecker: begin
				// odd squares get the inverted color
				wrPixel = checkerBits[settings.shading.checkerLog] ? ~fill : fill;
			end
			configTypes::shadeGradient: begin
				wrPixel.red = x[4:0];
				wrPixel.green = y[5:0];
				wrPixel.blue = fill.blue;
			end
			default: begin
				// solid, also mode 3
				wrPixel = fill;
			end
		endcase
	end

	assign wrEn = active;
	assign wrBuf = curBuf;
	assign wrIndex = idxWidth'(int'(row) * tileDim + int'(col));
	// high with the last write
	assign shadeDone = active && lastPixel;

endmodule

/* hdl/tileBufferPair.sv */
`timescale 1ns/1ps

module tileBufferPair #(
	parameter int tileDim = 8
) (
	input logic BOARD_CLK,
	input logic wrEn,
	input logic wrBuf,
	input logic [$clog2(tileDim*tileDim)-1:0] wrIndex,
	input rasterTypes::pixelRgb565 wrPixel,
	input logic rdBuf,
	input logic [$clog2(tileDim*tileDim)-1:0] rdIndex,
	output rasterTypes::pixelRgb565 rdPixel
);

	localparam int depth = tileDim * tileDim;

	// two tile halves
	// shader fills one while streamer drains the other
	rasterTypes::pixelRgb565 tileMem [2][depth];

	// write port, shader side
	always_ff @(posedge BOARD_CLK) begin
		if (wrEn) begin
			tileMem[wrBuf][wrIndex] <= wrPixel;
		end
	end

	// read port, one cycle latency
	// data is valid the cycle after rdIndex
	always_ff @(posedge BOARD_CLK) begin
		rdPixel <= tileMem[rdBuf][rdIndex];
	end

endmodule

/* hdl/tileStreamer.sv */
`timescale 1ns/1ps

module tileStreamer #(
	parameter int screenWidth = 640,
	parameter int tileDim = 8
) (
	input logic BOARD_CLK,
	input logic reset,
	input logic streamStart,
	input rasterTypes::tileOrigin streamOrigin,
	input logic streamBuf,
	output logic rdBuf,
	output logic [$clog2(tileDim*tileDim)-1:0] rdIndex,
	input rasterTypes::pixelRgb565 rdPixel,
	output rasterTypes::fbWrite fbOut,
	output logic streamDone
);

	localparam int coordWidth = $clog2(tileDim);
	localparam int idxWidth = $clog2(tileDim*tileDim);
	localparam int addrWidth = rasterTypes::fbAddrWidth;

	logic active;
	logic [coordWidth-1:0] col;
	logic [coordWidth-1:0] row;
	logic lastPixel;
	rasterTypes::tileOrigin origin;
	logic curBuf;
	// read stage delayed to line up with rdPixel
	logic validD;
	logic lastD;
	rasterTypes::screenCoord xD;
	rasterTypes::screenCoord yD;

	assign lastPixel = (col == coordWidth'(tileDim - 1)) && (row == coordWidth'(tileDim - 1));

	always_ff @(posedge BOARD_CLK) begin
		if (reset) begin
			active <= 1'b0;
			col <= '0;
			row <= '0;
			validD <= 1'b0;
			lastD <= 1'b0;
		end else begin
			validD <= active;
			lastD <= active && lastPixel;
			if (streamStart) begin
				active <= 1'b1;
				col <= '0;
				row <= '0;
			end else if (active) begin
				if (col == coordWidth'(tileDim - 1)) begin
					col <= '0;
					row <= row + 1'b1;
					active <= !lastPixel;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// tile position, plus coordinates one cycle behind the read
	always_ff @(posedge BOARD_CLK) begin
		if (streamStart) begin
			origin <= streamOrigin;
			curBuf <= streamBuf;
		end
		xD <= origin.x + rasterTypes::screenCoord'(col);
		yD <= origin.y + rasterTypes::screenCoord'(row);
	end

	assign rdBuf = curBuf;
	assign rdIndex = idxWidth'(int'(row) * tileDim + int'(col));

	// linear address y * width + x
	assign fbOut.valid = validD;
	assign fbOut.addr = addrWidth'(int'(yD) * screenWidth + int'(xD));
	assign fbOut.pixel = rdPixel;
	// same cycle as the last strobe
	assign streamDone = lastD;

endmodule

/* hdl/tileRenderer.sv */
`timescale 1ns/1ps

module tileRenderer #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480,
	parameter int tileDim = 8
) (
	input logic BOARD_CLK,
	input logic reset,
	input configTypes::cfgWrite cfgIn,
	input logic startFrame,
	output rasterTypes::fbWrite fbOut,
	output logic frameDone,
	output logic busy
);

	localparam int idxWidth = $clog2(tileDim*tileDim);

	// frame control
	logic frameStart;
	configTypes::renderSettings settings;

	// scheduler to shader
	logic shadeStart;
	rasterTypes::tileOrigin shadeOrigin;
	logic shadeBuf;
	logic shadeDone;

	// scheduler to streamer
	logic streamStart;
	rasterTypes::tileOrigin streamOrigin;
	logic streamBuf;
	logic streamDone;

	// tile buffer ports
	logic wrEn;
	logic wrBuf;
	logic [idxWidth-1:0] wrIndex;
	rasterTypes::pixelRgb565 wrPixel;
	logic rdBuf;
	logic [idxWidth-1:0] rdIndex;
	rasterTypes::pixelRgb565 rdPixel;

	renderConfig config0 (
		.BOARD_CLK(BOARD_CLK),
		.reset(reset),
		.cfgIn(cfgIn),
		.frameStart(frameStart),
		.settings(settings)
	);

	tileScheduler #(
		.screenWidth(screenWidth),
		.screenHeight(screenHeight),
		.tileDim(tileDim)
	) scheduler (
		.BOARD_CLK(BOARD_CLK),
		.reset(reset),
		.startFrame(startFrame),
		.frameStart(frameStart),
		.busy(busy),
		.frameDone(frameDone),
		.shadeStart(shadeStart),
		.shadeOrigin(shadeOrigin),
		.shadeBuf(shadeBuf),
		.shadeDone(shadeDone),
		.streamStart(streamStart),
		.streamOrigin(streamOrigin),
		.streamBuf(streamBuf),
		.streamDone(streamDone)
	);

	tileShader #(.tileDim(tileDim)) shader (
		.BOARD_CLK(BOARD_CLK),
		.reset(reset),
		.shadeStart(shadeStart),
		.shadeOrigin(shadeOrigin),
		.shadeBuf(shadeBuf),
		.settings(settings),
		.shadeDone(shadeDone),
		.wrEn(wrEn),
		.wrBuf(wrBuf),
		.wrIndex(wrIndex),
		.wrPixel(wrPixel)
	);

	// ping-pong halves
	tileBufferPair #(.tileDim(tileDim)) buffers (
		.BOARD_CLK(BOARD_CLK),
		.wrEn(wrEn),
		.wrBuf(wrBuf),
		.wrIndex(wrIndex),
		.wrPixel(wrPixel),
		.rdBuf(rdBuf),
		.rdIndex(rdIndex),
		.rdPixel(rdPixel)
	);

	tileStreamer #(
		.screenWidth(screenWidth),
		.tileDim(tileDim)
	) streamer (
		.BOARD_CLK(BOARD_CLK),
		.reset(reset),
		.streamStart(streamStart),
		.streamOrigin(streamOrigin),
		.streamBuf(streamBuf),
		.rdBuf(rdBuf),
		.rdIndex(rdIndex),
		.rdPixel(rdPixel),
		.fbOut(fbOut),
		.streamDone(streamDone)
	);

endmodule

/* verification/tileRenderer_props.sv */
`timescale 1ns/1ps

module tileRendererProps #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480
) (
	input logic BOARD_CLK,
	input logic reset,
	input rasterTypes::fbWrite fbOut,
	input logic frameDone,
	input logic busy
);

	// strobes stay inside the screen
	assert property (@(posedge BOARD_CLK) disable iff (reset)
		fbOut.valid |-> (int'(fbOut.addr) < screenWidth * screenHeight))
		else $error("framebuffer address outside the screen");

	// frameDone only inside a frame
	assert property (@(posedge BOARD_CLK) disable iff (reset)
		frameDone |-> busy)
		else $error("frameDone while not busy");

	// busy falls right after frameDone
	assert property (@(posedge BOARD_CLK) disable iff (reset)
		frameDone |=> !busy)
		else $error("busy still high one cycle after frameDone");

endmodule

bind tileRenderer tileRendererProps #(
	.screenWidth(screenWidth),
	.screenHeight(screenHeight)
) props (
	.BOARD_CLK(BOARD_CLK),
	.reset(reset),
	.fbOut(fbOut),
	.frameDone(frameDone),
	.busy(busy)
);

/* verification/tileRendererTb.sv */
`timescale 1ns/1ps

module tileRendererTb;

	localparam int screenWidth = 32;
	localparam int screenHeight = 16;
	localparam int tileDim = 8;
	localparam int pixelCount = screenWidth * screenHeight;
	localparam int tilesPerRow = screenWidth / tileDim;
	localparam int tilePixels = tileDim * tileDim;
	localparam int fixedRows = 8;
	localparam int lfsrRows = 3;
	localparam int numRows = fixedRows + lfsrRows;
	// rows that also run a follow-up frame
	localparam int latchRows = 2;
	// one frame is just under 600 cycles, plus config writes
	localparam int cyclesPerFrame = 700;
	localparam int cycleLimit = (numRows + latchRows) * cyclesPerFrame + 100;

	// fill color, mode word, disturb the frame while busy
	typedef struct packed {
		logic [15:0] fill;
		logic [15:0] mode;
		logic latch;
	} testRow;

	logic BOARD_CLK;
	logic reset;
	configTypes::cfgWrite cfgIn;
	logic startFrame;
	rasterTypes::fbWrite fbOut;
	logic frameDone;
	logic busy;

	testRow rows [numRows];
	logic [15:0] lfsrModes [lfsrRows];
	// shadow framebuffer filled from the strobes
	logic [15:0] shadow [pixelCount];
	logic [31:0] lfsrState;
	int cycleCount = 0;

	tileRenderer #(
		.screenWidth(screenWidth),
		.screenHeight(screenHeight),
		.tileDim(tileDim)
	) dut (
		.BOARD_CLK(BOARD_CLK),
		.reset(reset),
		.cfgIn(cfgIn),
		.startFrame(startFrame),
		.fbOut(fbOut),
		.frameDone(frameDone),
		.busy(busy)
	);

	// 100 ns period
	initial begin
		BOARD_CLK = 1'b0;
		forever #50 BOARD_CLK = ~BOARD_CLK;
	end

	// run limit
	always @(posedge BOARD_CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, the DUT never finished its frames", cycleCount);
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("Simulation failed");
			$fatal(1, "check failed");
		end
	endtask

	// galois form, shift right, toggle mask on a one out
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0]) begin
			lfsrStep = (s >> 1) ^ 32'h80200003;
		end else begin
			lfsrStep = s >> 1;
		end
	endfunction

	// one lfsr step per bit taken
	task automatic drawBits(input int count, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[14:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	// mode word: bits 1..0 mode, bits 3..2 checkerLog
	function automatic logic [15:0] expectedPixel(input int x, input int y,
			input logic [15:0] fill, input logic [15:0] mode);
		logic [9:0] xv;
		logic [9:0] yv;
		logic [9:0] diff;
		int side;
		xv = 10'(x);
		yv = 10'(y);
		diff = xv ^ yv;
		side = int'(mode[3:2]);
		case (mode[1:0])
			2'd1: expectedPixel = diff[side] ? ~fill : fill;
			2'd2: expectedPixel = {xv[4:0], yv[5:0], fill[4:0]};
			// solid, and value 3 too
			default: expectedPixel = fill;
		endcase
	endfunction

	// n-th strobe of a frame: tile raster order, row-major inside
	function automatic int expectedAddr(input int n);
		int tile;
		int inTile;
		int x;
		int y;
		tile = n / tilePixels;
		inTile = n % tilePixels;
		x = (tile % tilesPerRow) * tileDim + inTile % tileDim;
		y = (tile / tilesPerRow) * tileDim + inTile / tileDim;
		expectedAddr = y * screenWidth + x;
	endfunction

	task automatic buildTable();
		logic [15:0] color;
		rows[0] = {16'hF800, 16'h0000, 1'b0};
		// checker, checkerLog 0 to 3
		rows[1] = {16'h07E0, 16'h0001, 1'b0};
		rows[2] = {16'h001F, 16'h0005, 1'b0};
		rows[3] = {16'hA5C3, 16'h0009, 1'b1};
		rows[4] = {16'h3C0F, 16'h000D, 1'b0};
		rows[5] = {16'h0015, 16'h0002, 1'b0};
		// mode 3 falls back to solid
		rows[6] = {16'hFFE0, 16'h0003, 1'b1};
		// gradient ignores checkerLog
		rows[7] = {16'h1234, 16'h0006, 1'b0};
		lfsrModes[0] = 16'h0000;
		lfsrModes[1] = 16'h000D;
		lfsrModes[2] = 16'h0002;
		for (int i = 0; i < lfsrRows; i++) begin
			drawBits(16, color);
			rows[fixedRows + i] = {color, lfsrModes[i], 1'b0};
		end
	endtask

	// called just after a falling edge
	task automatic writeConfig(input logic addr, input logic [15:0] data);
		cfgIn = {1'b1, addr, data};
		@(negedge BOARD_CLK);
		cfgIn = '0;
	endtask

	task automatic runFrame(input logic [15:0] fill, input logic [15:0] mode, input logic latch);
		int n;
		int a;
		int cyc;
		int doneCount;
		int lastStrobeCyc;
		int stage;
		for (int i = 0; i < pixelCount; i++) begin
			shadow[i] = '0;
		end
		n = 0;
		cyc = 0;
		doneCount = 0;
		lastStrobeCyc = -10;
		stage = 0;
		startFrame = 1'b1;
		@(negedge BOARD_CLK);
		startFrame = 1'b0;
		checkTrue(busy, "busy did not rise after startFrame");
		while (!(doneCount > 0 && !busy)) begin
			// sample first, outputs settled since the rising edge
			if (fbOut.valid) begin
				checkTrue(n < pixelCount, "more pixel strobes than pixels in the frame");
				a = expectedAddr(n);
				checkValue("fbOut.addr", {12'h0, fbOut.addr}, a);
				// stored where the DUT said it goes
				shadow[fbOut.addr] = fbOut.pixel;
				n++;
				lastStrobeCyc = cyc;
			end
			if (frameDone) begin
				doneCount++;
				checkTrue(doneCount == 1, "frameDone pulsed more than once");
				checkTrue(n == pixelCount, "frameDone came before all pixels were written");
				checkTrue(lastStrobeCyc == cyc - 1, "frameDone did not follow the last strobe");
			end
			if (doneCount == 0) begin
				checkTrue(busy, "busy dropped before frameDone");
			end
			// mid-frame: new color, solid mode, a start that must be ignored
			if (latch && stage == 0 && n >= pixelCount / 2) begin
				cfgIn = {1'b1, configTypes::addrFillColor, ~fill};
				startFrame = 1'b1;
				stage = 1;
			end else if (stage == 1) begin
				cfgIn = {1'b1, configTypes::addrMode, 16'h0000};
				startFrame = 1'b0;
				stage = 2;
			end else if (stage == 2) begin
				cfgIn = '0;
				stage = 3;
			end
			@(negedge BOARD_CLK);
			cyc++;
		end
		// strobe order covers every address once, colors from the model
		for (int i = 0; i < pixelCount; i++) begin
			checkValue($sformatf("fbOut.pixel[%0h]", i), {16'h0, shadow[i]},
				{16'h0, expectedPixel(i % screenWidth, i / screenWidth, fill, mode)});
		end
	endtask

	initial begin
		reset = 1'b1;
		cfgIn = '0;
		startFrame = 1'b0;
		lfsrState = 32'h5432bda8;
		buildTable();
		repeat (3) @(negedge BOARD_CLK);
		reset = 1'b0;
		for (int r = 0; r < numRows; r++) begin
			writeConfig(configTypes::addrFillColor, rows[r].fill);
			writeConfig(configTypes::addrMode, rows[r].mode);
			runFrame(rows[r].fill, rows[r].mode, rows[r].latch);
			// no writes here, the mid-frame values must show up now
			if (rows[r].latch) begin
				runFrame(~rows[r].fill, 16'h0000, 1'b0);
			end
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

/* all.f */
hdl/rasterTypes.sv
hdl/configTypes.sv
hdl/renderConfig.sv
hdl/tileScheduler.sv
hdl/tileShader.sv
hdl/tileBufferPair.sv
hdl/tileStreamer.sv
hdl/tileRenderer.sv
verification/tileRenderer_props.sv
verification/tileRendererTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tileRendererTb
FILELIST = all.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
